//--- hdl/dds_pkg.sv
`default_nettype none

package dds_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths and types
   //////////////////////////////////////////////////////////////////////

   localparam int SAMPLE_W  = 12;
   localparam int PHASE_W   = 32;
   localparam int LFSR_W    = 5;
   localparam int KEY_COUNT = 17;    // 1..8, F1, F2, N, M, space, arrows

   typedef logic signed [SAMPLE_W-1:0] sample_t;   // two's complement
   typedef logic [PHASE_W-1:0]         phase_t;
   typedef logic [LFSR_W-1:0]          lfsr_t;
   typedef logic [KEY_COUNT-1:0]       key_vec_t;  // bit 16 is key 1, bit 0 down arrow

   typedef enum logic [1:0] {
      WAVE_SINE   = 2'd0,
      WAVE_COSINE = 2'd1,
      WAVE_SAW    = 2'd2,
      WAVE_SQUARE = 2'd3
   } wave_kind_t;

   typedef enum logic [1:0] {
      MOD_ASK  = 2'd0,
      MOD_BPSK = 2'd1,
      MOD_LFSR = 2'd2,
      MOD_OFF  = 2'd3
   } mod_kind_t;

   //////////////////////////////////////////////////////////////////////
   // constants
   //////////////////////////////////////////////////////////////////////

   localparam sample_t SAMPLE_MAX = 12'sd2047;        // negative side is -2047
   localparam sample_t LFSR_LEVEL = sample_t'(-2048); // shown for a one bit
   localparam lfsr_t   LFSR_SEED  = 5'b00001;

   // quarter-wave sine table
   localparam int     QUARTER_DEPTH   = 64;
   localparam string  SINE_TABLE_FILE = "hdl/sine_quarter.mem";
   localparam phase_t QUARTER_TURN    = 32'h4000_0000;  // 90 degrees of phase

   // keyboard event codes, key index i is base + i
   localparam logic [7:0] MAKE_BASE  = 8'h01;
   localparam logic [7:0] BREAK_BASE = 8'h81;

endpackage

`default_nettype wire

//--- hdl/wave_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// raw waveforms, a fresh set every clock
interface wave_bus_if
   import dds_pkg::*;
();

   sample_t sine;
   sample_t cosine;
   sample_t saw;
   sample_t square;

   modport source (output sine, cosine, saw, square);   // generator side

   modport sink (input sine, cosine, saw, square);      // modulator side

endinterface

`default_nettype wire

//--- hdl/dds_wave_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dds_wave_gen
   import dds_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  phase_t     phase_inc,
   wave_bus_if.source waves
);

   localparam int IDX_W = $clog2(QUARTER_DEPTH);

   sample_t sine_table [QUARTER_DEPTH];   // first quarter of the sine
   phase_t  phase;
   phase_t  cos_phase;

   initial
   begin
      $readmemh(SINE_TABLE_FILE, sine_table);
   end

   // full sine from the quarter table
   // bit 31 picks the sign, bit 30 mirrors the index
   function automatic sample_t quarter_lookup(input phase_t ph);
      logic [IDX_W-1:0] idx;
      sample_t          mag;
      begin
         idx = ph[PHASE_W-3 -: IDX_W];   // bits 29:24
         if (ph[PHASE_W-2])
         begin
            idx = ~idx;                  // 63 - idx
         end
         mag = sine_table[idx];
         return ph[PHASE_W-1] ? -mag : mag;
      end
   endfunction

   //////////////////////////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + phase_inc;   // wraps mod 2^32
   end

   assign cos_phase = phase + QUARTER_TURN;

   //////////////////////////////////////////////////////////////////////
   // shapers, one cycle behind the phase
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      waves.sine   <= quarter_lookup(phase);
      waves.cosine <= quarter_lookup(cos_phase);
      waves.saw    <= $signed(phase[PHASE_W-1 -: SAMPLE_W]);   // top 12 bits
      waves.square <= phase[PHASE_W-1] ? -SAMPLE_MAX : SAMPLE_MAX;
   end

   // square only ever sits at the two rails
   square_at_rails: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (waves.square == SAMPLE_MAX) || (waves.square == -SAMPLE_MAX));

endmodule

`default_nettype wire

//--- hdl/lfsr_noise_source.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_noise_source
   import dds_pkg::*;
#(
   parameter int unsigned LFSR_TICK_CYCLES = 25_000_000   // one step per second
)
(
   input  logic  CLK_25MHZ,
   input  logic  reset_from_key,
   output lfsr_t lfsr_state
);

   localparam int TICK_W = $clog2(LFSR_TICK_CYCLES + 1);

   logic [TICK_W-1:0] tick_count;
   logic              tick;

   //////////////////////////////////////////////////////////////////////
   // tick divider
   //////////////////////////////////////////////////////////////////////

   assign tick = (tick_count == TICK_W'(LFSR_TICK_CYCLES - 1));   // last count

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         tick_count <= '0;
      else if (tick)
         tick_count <= '0;
      else
         tick_count <= tick_count + 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // x^5 + x^3 + 1, 31 states
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr_state <= LFSR_SEED;
      else if (tick)
         lfsr_state <= {lfsr_state[LFSR_W-2:0], lfsr_state[4] ^ lfsr_state[2]};
   end

   // the all-zero state would lock up
   lfsr_never_zero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_state != '0);

endmodule

`default_nettype wire

//--- hdl/wave_modulator.sv
`timescale 1ns/1ps
`default_nettype none

module wave_modulator
   import dds_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   wave_bus_if.sink   waves,
   input  wave_kind_t wave_sel,
   input  mod_kind_t  mod_sel,
   input  lfsr_t      lfsr_state,
   output sample_t    wave_out,
   output sample_t    mod_out
);

   sample_t sel_wave;
   sample_t ask_wave;
   sample_t bpsk_wave;
   sample_t lfsr_wave;
   sample_t keyed;
   logic    key_bit;

   assign key_bit = lfsr_state[0];   // keying bit

   always_comb
   begin
      unique case (wave_sel)
         WAVE_SINE:   sel_wave = waves.sine;
         WAVE_COSINE: sel_wave = waves.cosine;
         WAVE_SAW:    sel_wave = waves.saw;
         WAVE_SQUARE: sel_wave = waves.square;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // keying
   //////////////////////////////////////////////////////////////////////

   assign ask_wave  = key_bit ? sel_wave : '0;          // on/off
   assign bpsk_wave = key_bit ? -sel_wave : sel_wave;   // 180 degree flip
   assign lfsr_wave = key_bit ? LFSR_LEVEL : '0;        // raw bit as a level

   always_comb
   begin
      unique case (mod_sel)
         MOD_ASK:  keyed = ask_wave;
         MOD_BPSK: keyed = bpsk_wave;
         MOD_LFSR: keyed = lfsr_wave;
         MOD_OFF:  keyed = '0;
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave_out <= '0;
         mod_out  <= '0;
      end
      else
      begin
         wave_out <= sel_wave;
         mod_out  <= keyed;
      end
   end

   // modulation switched off silences the output on the next edge
   mod_off_silent: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (mod_sel == MOD_OFF) |=> (mod_out == '0));

endmodule

`default_nettype wire

//--- hdl/key_state_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module key_state_tracker
   import dds_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  logic       kbd_event_ready,
   input  logic [7:0] kbd_event_code,
   output key_vec_t   key_state
);

   localparam int KEY_IDX_W = $clog2(KEY_COUNT);

   logic [7:0] make_offset;
   logic [7:0] break_offset;
   logic       is_make;
   logic       is_break;

   //////////////////////////////////////////////////////////////////////
   // event decode
   //////////////////////////////////////////////////////////////////////

   assign make_offset  = kbd_event_code - MAKE_BASE;
   assign break_offset = kbd_event_code - BREAK_BASE;

   // the two ranges do not overlap, other codes fall through
   assign is_make = kbd_event_ready
                    && (kbd_event_code >= MAKE_BASE)
                    && (make_offset < 8'(KEY_COUNT));
   assign is_break = kbd_event_ready
                     && (kbd_event_code >= BREAK_BASE)
                     && (break_offset < 8'(KEY_COUNT));

   //////////////////////////////////////////////////////////////////////
   // held-key vector
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         key_state <= '0;
      else if (is_make)
         key_state[make_offset[KEY_IDX_W-1:0]] <= 1'b1;    // pressed
      else if (is_break)
         key_state[break_offset[KEY_IDX_W-1:0]] <= 1'b0;   // released
   end

   // a single event byte moves at most one key
   one_key_per_event: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      $countones(key_state ^ $past(key_state)) <= 1);

endmodule

`default_nettype wire

//--- hdl/dds_lfsr_top.sv
`timescale 1ns/1ps
`default_nettype none

module dds_lfsr_top
   import dds_pkg::*;
#(
   parameter int unsigned LFSR_TICK_CYCLES = 25_000_000
)
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  phase_t     phase_inc,          // sets the output frequency
   input  wave_kind_t wave_sel,
   input  mod_kind_t  mod_sel,
   input  logic       kbd_event_ready,    // one-cycle pulse
   input  logic [7:0] kbd_event_code,
   output sample_t    wave_out,
   output sample_t    mod_out,
   output lfsr_t      lfsr_state,
   output key_vec_t   key_state
);

   wave_bus_if waves ();   // generator to modulator

   //////////////////////////////////////////////////////////////////////
   // DDS and LFSR keying
   //////////////////////////////////////////////////////////////////////

   dds_wave_gen u_dds_wave_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .waves          (waves.source)
   );

   lfsr_noise_source #(
      .LFSR_TICK_CYCLES (LFSR_TICK_CYCLES)
   ) u_lfsr_noise_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_state     (lfsr_state)        // also keys the modulator
   );

   wave_modulator u_wave_modulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .waves          (waves.sink),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .lfsr_state     (lfsr_state),
      .wave_out       (wave_out),
      .mod_out        (mod_out)
   );

   //////////////////////////////////////////////////////////////////////
   // keyboard
   //////////////////////////////////////////////////////////////////////

   key_state_tracker u_key_state_tracker (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .kbd_event_ready (kbd_event_ready),
      .kbd_event_code  (kbd_event_code),
      .key_state       (key_state)
   );

endmodule

`default_nettype wire

//--- verification/tb_dds_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dds_lfsr
   import dds_pkg::*;
();

   localparam int TICK_CYCLES = 16;
   localparam int DDS_CYCLES  = 48;
   localparam int LFSR_PERIOD = 31;

   logic       CLK_25MHZ = 1'b0;
   logic       reset_from_key;
   phase_t     phase_inc;
   wave_kind_t wave_sel;
   mod_kind_t  mod_sel;
   logic       kbd_event_ready;
   logic [7:0] kbd_event_code;
   sample_t    wave_out;
   sample_t    mod_out;
   lfsr_t      lfsr_state;
   key_vec_t   key_state;

   sample_t  tb_table [QUARTER_DEPTH];
   key_vec_t key_model;
   lfsr_t    prev_lfsr;                // state seen one negedge earlier
   int       seed;
   int       error_count  = 0;
   int       lfsr_changes = 0;         // since the last seed
   int       lfsr_moves   = 0;
   int       lfsr_periods = 0;
   logic     past_valid   = 1'b0;

   dds_lfsr_top #(
      .LFSR_TICK_CYCLES (TICK_CYCLES)
   ) u_dds_lfsr_top (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .phase_inc       (phase_inc),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .kbd_event_ready (kbd_event_ready),
      .kbd_event_code  (kbd_event_code),
      .wave_out        (wave_out),
      .mod_out         (mod_out),
      .lfsr_state      (lfsr_state),
      .key_state       (key_state)
   );

   initial
   begin
      forever #20 CLK_25MHZ = ~CLK_25MHZ;   // 40 ns period
   end

   always @(posedge CLK_25MHZ)
      past_valid <= 1'b1;

   task automatic flag_mismatch(input string name, input int expected, input int actual);
      begin
         error_count++;
         $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      end
   endtask

   task automatic flag_text(input string what);
      begin
         error_count++;
         $display("[ERROR] %0t %s", $time, what);
      end
   endtask

   task automatic check_value(input string name, input int expected, input int actual);
      begin
         assert (actual == expected)
         else
            flag_mismatch(name, expected, actual);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference models
   //////////////////////////////////////////////////////////////////////

   function automatic sample_t sine_of(input phase_t ph);
      int idx;
      begin
         idx = int'(ph[29:24]);
         case (ph[31:30])
            2'd0:    return tb_table[idx];
            2'd1:    return tb_table[QUARTER_DEPTH - 1 - idx];    // falling quarter
            2'd2:    return -tb_table[idx];
            default: return -tb_table[QUARTER_DEPTH - 1 - idx];
         endcase
      end
   endfunction

   function automatic sample_t shape_of(input wave_kind_t kind, input phase_t ph);
      begin
         case (kind)
            WAVE_SINE:   return sine_of(ph);
            WAVE_COSINE: return sine_of(ph + QUARTER_TURN);
            WAVE_SAW:    return sample_t'(ph[31:20]);
            default:     return ph[31] ? -SAMPLE_MAX : SAMPLE_MAX;
         endcase
      end
   endfunction

   function automatic sample_t mod_rule(input mod_kind_t kind, input sample_t w, input logic b);
      sample_t flipped;
      begin
         flipped = -w;
         case (kind)
            MOD_ASK:  return b ? w : sample_t'(0);
            MOD_BPSK: return b ? flipped : w;
            MOD_LFSR: return b ? LFSR_LEVEL : sample_t'(0);
            default:  return '0;   // off
         endcase
      end
   endfunction

   function automatic lfsr_t lfsr_step(input lfsr_t s);
      begin
         return {s[3:0], s[4] ^ s[2]};
      end
   endfunction

   function automatic key_vec_t apply_key_event(input key_vec_t keys, input logic [7:0] code);
      key_vec_t next_keys;
      int       make_idx;
      int       break_idx;
      begin
         next_keys = keys;
         make_idx  = int'(code) - int'(MAKE_BASE);
         break_idx = int'(code) - int'(BREAK_BASE);
         if (make_idx >= 0 && make_idx < KEY_COUNT)
            next_keys[make_idx] = 1'b1;
         else if (break_idx >= 0 && break_idx < KEY_COUNT)
            next_keys[break_idx] = 1'b0;
         return next_keys;
      end
   endfunction

   //////////////////////////////////////////////////////////////////////
   // per-cycle checks
   //////////////////////////////////////////////////////////////////////

   // runs at every negedge, before any input moves
   task automatic watch_outputs();
      begin
         if (reset_from_key)
            lfsr_changes = 0;
         else if (lfsr_state == prev_lfsr)
            check_value("mod_out", mod_rule(mod_sel, wave_out, lfsr_state[0]), mod_out);
         else
         begin
            check_value("lfsr_state", lfsr_step(prev_lfsr), lfsr_state);
            lfsr_changes++;
            lfsr_moves++;
            if (lfsr_state == LFSR_SEED || lfsr_changes == LFSR_PERIOD)
            begin
               check_value("lfsr_state", LFSR_SEED, lfsr_state);
               check_value("lfsr changes per period", LFSR_PERIOD, lfsr_changes);
               lfsr_changes = 0;
               lfsr_periods++;
            end
         end
         prev_lfsr = lfsr_state;
      end
   endtask

   task automatic next_cycle();
      begin
         @(negedge CLK_25MHZ);
         watch_outputs();
      end
   endtask

   task automatic hold_reset();
      begin
         reset_from_key = 1'b1;
         repeat (2)
            next_cycle();
         reset_from_key = 1'b0;
         key_model      = '0;
      end
   endtask

   // drives one keyboard byte per cycle and checks it on the next negedge
   task automatic key_cycle();
      int pick;
      int key;
      begin
         next_cycle();
         check_value("key_state", key_model, key_state);
         pick = $unsigned($random(seed)) % 8;
         key  = $unsigned($random(seed)) % KEY_COUNT;
         kbd_event_ready = (pick < 6);
         if (pick < 3)
            kbd_event_code = MAKE_BASE + 8'(key);
         else if (pick < 5)
            kbd_event_code = BREAK_BASE + 8'(key);
         else
            kbd_event_code = 8'($random(seed));   // stray byte
         if (kbd_event_ready)
            key_model = apply_key_event(key_model, kbd_event_code);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // reset values and LFSR lockup
   //////////////////////////////////////////////////////////////////////

   wave_out_reset: assert property (@(posedge CLK_25MHZ)
      (past_valid && $past(reset_from_key)) |-> (wave_out == '0))
      else flag_mismatch("wave_out", 0, $sampled(wave_out));

   mod_out_reset: assert property (@(posedge CLK_25MHZ)
      (past_valid && $past(reset_from_key)) |-> (mod_out == '0))
      else flag_mismatch("mod_out", 0, $sampled(mod_out));

   key_state_reset: assert property (@(posedge CLK_25MHZ)
      (past_valid && $past(reset_from_key)) |-> (key_state == '0))
      else flag_mismatch("key_state", 0, $sampled(key_state));

   lfsr_seed_reset: assert property (@(posedge CLK_25MHZ)
      (past_valid && $past(reset_from_key)) |-> (lfsr_state == LFSR_SEED))
      else flag_mismatch("lfsr_state", LFSR_SEED, $sampled(lfsr_state));

   lfsr_nonzero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      past_valid |-> (lfsr_state != '0))
      else flag_text("lfsr_state fell into the all-zero state");

   initial
   begin
      int     wait_count;
      int     moves_before;
      phase_t model_phase;
      seed            = 32'hcf91ac6e;
      reset_from_key  = 1'b1;
      phase_inc       = '0;
      wave_sel        = WAVE_SINE;
      mod_sel         = MOD_OFF;
      kbd_event_ready = 1'b0;
      kbd_event_code  = 8'h00;
      key_model       = '0;
      prev_lfsr       = LFSR_SEED;
      $readmemh(SINE_TABLE_FILE, tb_table);
      check_value("sine table peak", SAMPLE_MAX, tb_table[QUARTER_DEPTH-1]);

      // each wave shape starts from a fresh reset so the edge count restarts
      for (int k = 0; k < 4; k++)
      begin
         phase_inc = $random(seed);
         wave_sel  = wave_kind_t'(k);
         mod_sel   = mod_kind_t'($unsigned($random(seed)) % 4);
         hold_reset();
         model_phase = '0;
         for (int n = 1; n <= DDS_CYCLES; n++)
         begin
            next_cycle();
            if (n >= 2)
            begin
               check_value("wave_out", shape_of(wave_sel, model_phase), wave_out);
               model_phase = model_phase + phase_inc;
            end
         end
      end

      // every keying mode across two LFSR steps with keyboard traffic alongside
      phase_inc = $random(seed);
      hold_reset();
      for (int m = 0; m < 4; m++)
      begin
         mod_sel      = mod_kind_t'(m);
         wave_sel     = wave_kind_t'($unsigned($random(seed)) % 4);
         moves_before = lfsr_moves;
         wait_count   = 0;
         while (lfsr_moves < moves_before + 2 && wait_count < 3 * TICK_CYCLES)
         begin
            key_cycle();
            wait_count++;
         end
         if (lfsr_moves < moves_before + 2)
            flag_text("timeout, lfsr_state did not take two steps under one mod_sel");
         repeat (8)
            key_cycle();
      end

      wait_count = 0;
      while (lfsr_periods == 0 && wait_count < (LFSR_PERIOD + 8) * TICK_CYCLES)
      begin
         key_cycle();
         wait_count++;
      end
      if (lfsr_periods == 0)
         flag_text("timeout, lfsr_state never came back to its seed");
      next_cycle();
      check_value("key_state", key_model, key_state);

      $display("simulation finished with %0d errors", error_count);
      if (error_count == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
hdl/dds_pkg.sv
hdl/wave_bus_if.sv
hdl/dds_wave_gen.sv
hdl/lfsr_noise_source.sv
hdl/wave_modulator.sv
hdl/key_state_tracker.sv
hdl/dds_lfsr_top.sv
verification/tb_dds_lfsr.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_dds_lfsr
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/sine_quarter.mem
019
04B
07E
0B0
0E2
113
145
177
1A8
1D9
20A
23A
26A
29A
2C9
2F8
327
354
382
3AF
3DB
407
432
45C
486
4AF
4D7
4FF
526
54C
571
596
5B9
5DC
5FD
61E
63E
65D
67B
698
6B4
6CF
6E9
701
719
730
745
759
76D
77F
790
79F
7AE
7BB
7C8
7D3
7DC
7E5
7EC
7F3
7F7
7FB
7FE
7FF
